//--- tile_dispatch.f
verilog/tile_task_pkg.sv
verilog/tile_host_pkg.sv
verilog/task_fifo.sv
verilog/conflict_serializer.sv
verilog/host_task_port.sv
verilog/tile_dispatch.sv
dv/tile_dispatch_props.sv
dv/tile_dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the tile dispatch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f tile_dispatch.f --top-module tile_dispatch_tb \
   -Mdir obj_dir -o tile_dispatch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tile_dispatch_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- dv/tile_dispatch_tb.sv
module tile_dispatch_tb;

   localparam int N_CORES    = 4;
   localparam int WAIT_LIMIT = 2000;
   localparam int N_ROWS     = 11;

   localparam tile_task_pkg::task_type_t RELAX  = tile_task_pkg::TYPE_RELAX;
   localparam tile_task_pkg::task_type_t VISIT  = tile_task_pkg::TYPE_VISIT;
   localparam tile_task_pkg::task_type_t UPDATE = tile_task_pkg::TYPE_UPDATE;
   localparam tile_task_pkg::task_type_t COMMIT = tile_task_pkg::TYPE_COMMIT;
   localparam logic [1:0] OKAY   = tile_host_pkg::RESP_OKAY;
   localparam logic [1:0] SLVERR = tile_host_pkg::RESP_SLVERR;

   typedef struct {
      string                     name;
      tile_host_pkg::axil_addr_t addr;
      tile_task_pkg::ts_t        ts;
      tile_task_pkg::task_type_t ttype;
      tile_task_pkg::task_arg_t  arg;
      logic [1:0]                resp;
   } row_t;

   logic                                    clk_main_a0;
   logic                                    rst_main_n_sync;
   tile_host_pkg::axil_addr_t               awaddr;
   logic                                    awvalid;
   logic                                    awready;
   tile_host_pkg::axil_data_t               wdata;
   logic [3:0]                              wstrb;
   logic                                    wvalid;
   logic                                    wready;
   logic [1:0]                              bresp;
   logic                                    bvalid;
   logic                                    bready;
   tile_host_pkg::axil_addr_t               araddr;
   logic                                    arvalid;
   logic                                    arready;
   tile_host_pkg::axil_data_t               rdata;
   logic [1:0]                              rresp;
   logic                                    rvalid;
   logic                                    rready;
   logic [N_CORES-1:0]                      core_req_valid;
   tile_task_pkg::task_type_t [N_CORES-1:0] core_req_type;
   logic [N_CORES-1:0]                      core_finish;
   logic [N_CORES-1:0]                      core_task_valid;
   tile_task_pkg::task_t                    core_task_data;

   // Scoreboard and core model state
   tile_task_pkg::task_t     exp_q [$];
   logic [N_CORES-1:0]       core_busy;
   tile_task_pkg::task_arg_t core_arg [N_CORES];
   int                       hold_left [N_CORES];
   logic                     cores_enabled;
   int                       seed;
   int                       accepted;
   int                       error_count;

   // Rows sharing arg 0x020 must serialize
   row_t rows [N_ROWS] = '{
      '{"relax_first",     8'h00, 16'd1,  RELAX,  12'h010, OKAY},
      '{"visit_first",     8'h00, 16'd2,  VISIT,  12'h011, OKAY},
      '{"update_first",    8'h00, 16'd3,  UPDATE, 12'h012, OKAY},
      '{"commit_first",    8'h00, 16'd4,  COMMIT, 12'h013, OKAY},
      '{"unmapped_write",  8'h10, 16'd0,  RELAX,  12'h0ff, SLVERR},
      '{"same_arg_relax",  8'h00, 16'd5,  RELAX,  12'h020, OKAY},
      '{"same_arg_visit",  8'h00, 16'd6,  VISIT,  12'h020, OKAY},
      '{"same_arg_update", 8'h00, 16'd7,  UPDATE, 12'h020, OKAY},
      '{"relax_second",    8'h00, 16'd8,  RELAX,  12'h030, OKAY},
      '{"commit_second",   8'h00, 16'd9,  COMMIT, 12'h031, OKAY},
      '{"visit_second",    8'h00, 16'd10, VISIT,  12'h032, OKAY}
   };

   tile_dispatch #(
      .N_CORES   (N_CORES),
      .LOG_DEPTH (3)
   ) UUT (.*);

   initial begin
      clk_main_a0 = 1'b0;
      forever #10 clk_main_a0 = ~clk_main_a0;
   end

   task automatic stop_with_failure(input string msg);
      error_count++;
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error: %s: expected %h, actual %h", name, expected, actual);
         stop_with_failure("Value mismatch");
      end
   endtask

   function automatic logic host_flag(input int sel);
      case (sel)
         0: return awready && wready;
         1: return bvalid;
         2: return arready;
         3: return rvalid;
         4: return exp_q.size() == 0 && core_busy == '0;
         default: return exp_q.size() == 0 && core_busy != '0;
      endcase
   endfunction

   // Polls at the falling edge where outputs are settled
   task automatic wait_host(input int sel, input string what);
      int t;
      t = 0;
      @(negedge clk_main_a0);
      while (!host_flag(sel)) begin
         t++;
         if (t > WAIT_LIMIT) stop_with_failure({"Timeout waiting for ", what});
         @(negedge clk_main_a0);
      end
   endtask

   task automatic host_write(input tile_host_pkg::axil_addr_t addr,
                             input tile_host_pkg::axil_data_t data, output logic [1:0] resp);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      wait_host(0, "write acceptance");
      @(posedge clk_main_a0);
      #2;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      wait_host(1, "write response");
      resp = bresp;
      // bready trails bvalid by a cycle so the response has to hold
      @(posedge clk_main_a0);
      #2;
      bready = 1'b1;
      @(posedge clk_main_a0);
      #2;
      bready = 1'b0;
   endtask

   task automatic host_read(input tile_host_pkg::axil_addr_t addr,
                            output tile_host_pkg::axil_data_t data, output logic [1:0] resp);
      araddr  = addr;
      arvalid = 1'b1;
      wait_host(2, "read acceptance");
      @(posedge clk_main_a0);
      #2;
      arvalid = 1'b0;
      wait_host(3, "read data");
      data = rdata;
      resp = rresp;
      @(posedge clk_main_a0);
      #2;
      rready = 1'b1;
      @(posedge clk_main_a0);
      #2;
      rready = 1'b0;
   endtask

   task automatic enqueue_task(input string name, input tile_task_pkg::task_t tsk);
      logic [1:0] resp;
      exp_q.push_back(tsk);
      accepted++;
      host_write(tile_host_pkg::REG_TASK_ENQ, tsk, resp);
      check_value({name, " bresp"}, OKAY, resp);
   endtask

   task automatic check_status(input string name, input int count, input logic done);
      tile_host_pkg::axil_data_t data;
      logic [1:0]                resp;
      host_read(tile_host_pkg::REG_ENQ_COUNT, data, resp);
      check_value({name, " enq count"}, count, data);
      host_read(tile_host_pkg::REG_DISPATCH_COUNT, data, resp);
      check_value({name, " dispatch count"}, count, data);
      host_read(tile_host_pkg::REG_DONE, data, resp);
      check_value({name, " done"}, done, data);
      check_value({name, " done rresp"}, OKAY, resp);
   endtask

   // Cores 0 and 1 run RELAX or VISIT, cores 2 and 3 run UPDATE or COMMIT
   initial begin : core_models
      int                   c;
      int                   d;
      int                   k;
      int                   idx;
      tile_task_pkg::task_t got;
      forever begin
         @(posedge clk_main_a0);
         #2;
         core_finish = '0;
         got = core_task_data;
         for (c = 0; c < N_CORES; c++) begin
            if (core_task_valid[c]) begin
               if (core_busy[c] || !core_req_valid[c])
                  stop_with_failure($sformatf("Core %0d got a task it did not ask for", c));
               check_value($sformatf("core %0d request type", c), core_req_type[c], got.ttype);
               for (d = 0; d < N_CORES; d++) begin
                  if (core_busy[d] && core_arg[d] == got.arg)
                     stop_with_failure($sformatf("Cores %0d and %0d share an arg", c, d));
               end
               // Oldest outstanding task of this type is the one due
               idx = -1;
               for (k = 0; k < exp_q.size(); k++) begin
                  if (idx < 0 && exp_q[k].ttype == got.ttype) idx = k;
               end
               if (idx < 0) stop_with_failure("A task was dispatched that was never written");
               check_value($sformatf("core %0d task data", c), exp_q[idx], got);
               exp_q.delete(idx);
               core_busy[c]      = 1'b1;
               core_arg[c]       = got.arg;
               hold_left[c]      = 1 + ($random(seed) & 7);
               core_req_valid[c] = 1'b0;
            end else if (core_busy[c]) begin
               if (cores_enabled) begin
                  hold_left[c]--;
                  if (hold_left[c] == 0) begin
                     core_finish[c] = 1'b1;
                     core_busy[c]   = 1'b0;
                  end
               end
            end else begin
               core_req_valid[c] = cores_enabled;
               if ($random(seed) & 1) core_req_type[c] = (c < 2) ? VISIT : COMMIT;
               else core_req_type[c] = (c < 2) ? RELAX : UPDATE;
            end
         end
      end
   end

   initial begin : stimulus
      int                        r;
      logic [1:0]                resp;
      tile_host_pkg::axil_data_t data;
      tile_task_pkg::task_t      tsk;
      seed            = 32'hc3aeecff;
      error_count     = 0;
      accepted        = 0;
      cores_enabled   = 1'b1;
      core_busy       = '0;
      rst_main_n_sync = 1'b0;
      awaddr          = '0;
      awvalid         = 1'b0;
      wdata           = '0;
      wstrb           = 4'hf;
      wvalid          = 1'b0;
      bready          = 1'b0;
      araddr          = '0;
      arvalid         = 1'b0;
      rready          = 1'b0;
      core_req_valid  = '0;
      core_req_type   = {N_CORES{RELAX}};
      core_finish     = '0;
      repeat (5) @(posedge clk_main_a0);
      #2;
      rst_main_n_sync = 1'b1;
      check_status("after reset", 0, 1'b1);

      for (r = 0; r < N_ROWS; r++) begin
         tsk = '{ts: rows[r].ts, ttype: rows[r].ttype, arg: rows[r].arg};
         if (rows[r].resp == OKAY) begin
            enqueue_task(rows[r].name, tsk);
         end else begin
            host_write(rows[r].addr, tsk, resp);
            check_value({rows[r].name, " bresp"}, rows[r].resp, resp);
            host_read(tile_host_pkg::REG_ENQ_COUNT, data, resp);
            check_value({rows[r].name, " enq count"}, accepted, data);
         end
      end
      wait_host(4, "table tasks to finish");
      repeat (3) @(posedge clk_main_a0);
      #2;
      check_status("table drained", accepted, 1'b1);

      // Silent cores let the FIFO fill, the ninth write has to wait
      cores_enabled = 1'b0;
      for (r = 0; r < 9; r++) begin
         tsk = '{ts: 16'(100 + r), ttype: tile_task_pkg::task_type_t'(r % 4),
                 arg: 12'(12'h100 + r)};
         if (r < 8) begin
            enqueue_task("fifo_fill", tsk);
         end else begin
            fork
               enqueue_task("fifo_overflow", tsk);
               begin
                  repeat (10) @(negedge clk_main_a0);
                  // Both channels still offered and still refused
                  check_value("overflow awready stalled", 1, awvalid && !awready);
                  check_value("overflow wready stalled", 1, wvalid && !wready);
                  cores_enabled = 1'b1;
               end
            join
         end
      end

      // Freeze the last running task with the queue empty and look at the done flag
      wait_host(5, "the last task to start");
      cores_enabled = 1'b0;
      @(posedge clk_main_a0);
      #2;
      host_read(tile_host_pkg::REG_DONE, data, resp);
      check_value("done while a core is busy", 0, data);
      cores_enabled = 1'b1;

      wait_host(4, "all tasks to finish");
      repeat (3) @(posedge clk_main_a0);
      #2;
      check_status("final", accepted, 1'b1);

      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- dv/tile_dispatch_props.sv
module tile_dispatch_props #(
   parameter int N_CORES = 4
) (
   input logic               clk_main_a0,
   input logic               rst_main_n_sync,
   input logic [N_CORES-1:0] core_task_valid,
   input logic [N_CORES-1:0] core_finish,
   input logic [31:0]        dispatch_count,
   input logic [1:0]         bresp,
   input logic               bvalid,
   input logic               bready,
   input logic [31:0]        rdata,
   input logic               rvalid,
   input logic               rready
);

   // Cores holding a task, as seen on the core interface
   logic [N_CORES-1:0] running;

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         running <= '0;
      end else begin
         running <= (running & ~core_finish) | core_task_valid;
      end
   end

   // At most one grant per cycle and each grant counted once
   one_grant_per_cycle: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      $onehot0(core_task_valid) &&
      (dispatch_count == $past(dispatch_count) + $countones(core_task_valid)))
      else $error("more than one core granted in one cycle");

   // A running core must not be handed a second task
   no_grant_to_busy: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      (core_task_valid & running) == '0)
      else $error("task granted to a busy core");

   bvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("write response dropped before bready");

   rvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("read data dropped before rready");

endmodule

// Attached at the top so both the core side and the host port are visible
bind tile_dispatch tile_dispatch_props #(.N_CORES(N_CORES)) props (
   .clk_main_a0     (clk_main_a0),
   .rst_main_n_sync (rst_main_n_sync),
   .core_task_valid (core_task_valid),
   .core_finish     (core_finish),
   .dispatch_count  (dispatch_count),
   .bresp           (bresp),
   .bvalid          (bvalid),
   .bready          (bready),
   .rdata           (rdata),
   .rvalid          (rvalid),
   .rready          (rready)
);

//--- verilog/tile_dispatch.sv
module tile_dispatch #(
   parameter int N_CORES   = tile_task_pkg::DEFAULT_N_CORES,
   parameter int LOG_DEPTH = tile_task_pkg::DEFAULT_LOG_DEPTH
) (
   input  logic                                    clk_main_a0,
   input  logic                                    rst_main_n_sync,

   // Host AXI4-Lite slave
   input  tile_host_pkg::axil_addr_t                awaddr,
   input  logic                                    awvalid,
   output logic                                    awready,
   input  tile_host_pkg::axil_data_t                wdata,
   input  logic [3:0]                              wstrb,
   input  logic                                    wvalid,
   output logic                                    wready,
   output logic [1:0]                              bresp,
   output logic                                    bvalid,
   input  logic                                    bready,
   input  tile_host_pkg::axil_addr_t                araddr,
   input  logic                                    arvalid,
   output logic                                    arready,
   output tile_host_pkg::axil_data_t                rdata,
   output logic [1:0]                              rresp,
   output logic                                    rvalid,
   input  logic                                    rready,

   // Cores
   input  logic [N_CORES-1:0]                      core_req_valid,
   input  tile_task_pkg::task_type_t [N_CORES-1:0] core_req_type,
   input  logic [N_CORES-1:0]                      core_finish,
   output logic [N_CORES-1:0]                      core_task_valid,
   output tile_task_pkg::task_t                    core_task_data
);

   logic                 push_valid;
   tile_task_pkg::task_t push_task;
   logic                 fifo_full;
   logic                 fifo_empty;
   logic                 head_valid;
   tile_task_pkg::task_t head_task;
   logic                 pop;
   logic                 all_idle;
   logic [31:0]          dispatch_count;

   host_task_port host_port (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .awaddr          (awaddr),
      .awvalid         (awvalid),
      .awready         (awready),
      .wdata           (wdata),
      .wstrb           (wstrb),
      .wvalid          (wvalid),
      .wready          (wready),
      .bresp           (bresp),
      .bvalid          (bvalid),
      .bready          (bready),
      .araddr          (araddr),
      .arvalid         (arvalid),
      .arready         (arready),
      .rdata           (rdata),
      .rresp           (rresp),
      .rvalid          (rvalid),
      .rready          (rready),
      .push_valid      (push_valid),
      .push_task       (push_task),
      .full            (fifo_full),
      .fifo_empty      (fifo_empty),
      .all_idle        (all_idle),
      .dispatch_count  (dispatch_count)
   );

   // Out-task queue between host and cores
   task_fifo #(
      .LOG_DEPTH (LOG_DEPTH)
   ) out_task_fifo (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .push_valid      (push_valid),
      .push_task       (push_task),
      .full            (fifo_full),
      .empty           (fifo_empty),
      .head_valid      (head_valid),
      .head_task       (head_task),
      .pop             (pop)
   );

   conflict_serializer #(
      .N_CORES (N_CORES)
   ) serializer (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .head_valid      (head_valid),
      .head_task       (head_task),
      .pop             (pop),
      .core_req_valid  (core_req_valid),
      .core_req_type   (core_req_type),
      .core_finish     (core_finish),
      .core_task_valid (core_task_valid),
      .core_task_data  (core_task_data),
      .all_idle        (all_idle),
      .dispatch_count  (dispatch_count)
   );

endmodule

//--- verilog/host_task_port.sv
module host_task_port (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,

   // AXI4-Lite write address and data
   input  tile_host_pkg::axil_addr_t awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  tile_host_pkg::axil_data_t wdata,
   input  logic [3:0]               wstrb,
   input  logic                     wvalid,
   output logic                     wready,

   // AXI4-Lite write response
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,

   // AXI4-Lite read address and data
   input  tile_host_pkg::axil_addr_t araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output tile_host_pkg::axil_data_t rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,

   // Task FIFO write side
   output logic                     push_valid,
   output tile_task_pkg::task_t     push_task,
   input  logic                     full,

   // Status from the dispatch path
   input  logic                     fifo_empty,
   input  logic                     all_idle,
   input  logic [31:0]              dispatch_count
);

   tile_host_pkg::host_state_t state;
   tile_host_pkg::axil_data_t  enq_count;
   logic                       done;

   logic                       addr_is_enq;
   logic                       task_write;
   logic                       wr_accept;
   logic                       rd_accept;
   tile_host_pkg::axil_data_t  rd_data_next;
   logic [1:0]                 rd_resp_next;

   // A task is a whole word, so only full-strobe writes enqueue
   assign addr_is_enq = (awaddr == tile_host_pkg::REG_TASK_ENQ);
   assign task_write  = addr_is_enq && (&wstrb);

   // Task writes stall while the FIFO is full
   assign wr_accept = (state == tile_host_pkg::HOST_IDLE) && awvalid && wvalid &&
                      !(addr_is_enq && full);
   assign awready   = wr_accept;
   assign wready    = wr_accept;

   // Write wins when both channels arrive together
   assign arready   = (state == tile_host_pkg::HOST_IDLE) && !wr_accept;
   assign rd_accept = arvalid && arready;

   assign push_valid = wr_accept && task_write;
   assign push_task  = tile_task_pkg::task_t'(wdata);

   assign bvalid = (state == tile_host_pkg::HOST_WRESP);
   assign rvalid = (state == tile_host_pkg::HOST_RRESP);

   // Status read decode
   always_comb begin
      rd_data_next = '0;
      rd_resp_next = tile_host_pkg::RESP_OKAY;
      case (araddr)
         tile_host_pkg::REG_ENQ_COUNT: begin
            rd_data_next = enq_count;
         end
         tile_host_pkg::REG_DISPATCH_COUNT: begin
            rd_data_next = dispatch_count;
         end
         tile_host_pkg::REG_DONE: begin
            rd_data_next = tile_host_pkg::axil_data_t'(done);
         end
         default: begin
            // Enqueue register is write-only
            rd_resp_next = tile_host_pkg::RESP_SLVERR;
         end
      endcase
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         state     <= tile_host_pkg::HOST_IDLE;
         enq_count <= '0;
         done      <= 1'b1;
      end else begin
         // Tile is done once the queue drains and no core holds a task
         done <= fifo_empty & all_idle;
         if (push_valid) begin
            enq_count <= enq_count + 1'b1;
         end
         case (state)
            tile_host_pkg::HOST_IDLE: begin
               if (wr_accept) begin
                  state <= tile_host_pkg::HOST_WRESP;
               end else if (rd_accept) begin
                  state <= tile_host_pkg::HOST_RRESP;
               end
            end
            tile_host_pkg::HOST_WRESP: begin
               if (bready) begin
                  state <= tile_host_pkg::HOST_IDLE;
               end
            end
            tile_host_pkg::HOST_RRESP: begin
               if (rready) begin
                  state <= tile_host_pkg::HOST_IDLE;
               end
            end
            default: begin
               state <= tile_host_pkg::HOST_IDLE;
            end
         endcase
      end
   end

   // Response payload, held until the host takes it
   always_ff @(posedge clk_main_a0) begin
      if (wr_accept) begin
         bresp <= task_write ? tile_host_pkg::RESP_OKAY : tile_host_pkg::RESP_SLVERR;
      end
      if (rd_accept) begin
         rdata <= rd_data_next;
         rresp <= rd_resp_next;
      end
   end

endmodule

//--- verilog/conflict_serializer.sv
module conflict_serializer #(
   parameter int N_CORES = 4
) (
   input  logic                                    clk_main_a0,
   input  logic                                    rst_main_n_sync,

   // Head of the task FIFO
   input  logic                                    head_valid,
   input  tile_task_pkg::task_t                    head_task,
   output logic                                    pop,

   // Core side
   input  logic [N_CORES-1:0]                      core_req_valid,
   input  tile_task_pkg::task_type_t [N_CORES-1:0] core_req_type,
   input  logic [N_CORES-1:0]                      core_finish,
   output logic [N_CORES-1:0]                      core_task_valid,
   output tile_task_pkg::task_t                    core_task_data,

   // Status
   output logic                                    all_idle,
   output logic [31:0]                             dispatch_count
);

   logic [N_CORES-1:0]      busy;
   tile_task_pkg::task_arg_t busy_arg [N_CORES];

   logic [N_CORES-1:0]      arg_match;
   logic [N_CORES-1:0]      type_match;
   logic                    conflict;
   logic [N_CORES-1:0]      eligible;
   logic [N_CORES-1:0]      grant_vec;

   for (genvar i = 0; i < N_CORES; i++) begin : g_core
      // Running task on this core touches the same object as the head
      assign arg_match[i] = busy[i] && (busy_arg[i] == head_task.arg);
      // Busy cores are not listened to
      assign type_match[i] = core_req_valid[i] && !busy[i] &&
                             (core_req_type[i] == head_task.ttype);
   end

   assign conflict = |arg_match;

   // A blocked head also holds back everything behind it
   assign eligible = (head_valid && !conflict) ? type_match : '0;

   // Keep only the lowest set bit
   assign grant_vec = eligible & (~eligible + 1'b1);

   assign pop      = |grant_vec;
   assign all_idle = ~|busy;

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         busy            <= '0;
         core_task_valid <= '0;
         dispatch_count  <= '0;
      end else begin
         // Finish clears, grant sets; a granted core was idle so they never collide
         busy            <= (busy & ~core_finish) | grant_vec;
         core_task_valid <= grant_vec;
         if (pop) begin
            dispatch_count <= dispatch_count + 1'b1;
         end
      end
   end

   // Task word and per-core argument follow the grant
   always_ff @(posedge clk_main_a0) begin
      if (pop) begin
         core_task_data <= head_task;
      end
      for (int i = 0; i < N_CORES; i++) begin
         if (grant_vec[i]) begin
            busy_arg[i] <= head_task.arg;
         end
      end
   end

endmodule

//--- verilog/task_fifo.sv
module task_fifo #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n_sync,

   input  logic                 push_valid,
   input  tile_task_pkg::task_t push_task,
   output logic                 full,
   output logic                 empty,

   output logic                 head_valid,
   output tile_task_pkg::task_t head_task,
   input  logic                 pop
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   tile_task_pkg::task_t mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0]   count;
   logic                 do_push;
   logic                 do_pop;

   assign full       = (count == DEPTH[LOG_DEPTH:0]);
   assign empty      = (count == '0);
   assign head_valid = !empty;
   assign head_task  = mem[rd_ptr];

   assign do_push = push_valid && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk_main_a0) begin
      if (do_push) begin
         mem[wr_ptr] <= push_task;
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap naturally at the power-of-two depth
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- verilog/tile_host_pkg.sv
package tile_host_pkg;

   typedef logic [7:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;

   // Register map
   localparam axil_addr_t REG_TASK_ENQ       = 8'h00;
   localparam axil_addr_t REG_ENQ_COUNT      = 8'h04;
   localparam axil_addr_t REG_DISPATCH_COUNT = 8'h08;
   localparam axil_addr_t REG_DONE           = 8'h0C;

   // AXI4-Lite response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Host port response FSM
   typedef enum logic [1:0] {
      HOST_IDLE,
      HOST_WRESP,
      HOST_RRESP
   } host_state_t;

endpackage

//--- verilog/tile_task_pkg.sv
package tile_task_pkg;

   // Kinds of work a core can ask for
   typedef enum logic [3:0] {
      TYPE_RELAX  = 4'd0,
      TYPE_VISIT  = 4'd1,
      TYPE_UPDATE = 4'd2,
      TYPE_COMMIT = 4'd3
   } task_type_t;

   // Task timestamp
   typedef logic [15:0] ts_t;

   // Object touched by the task, equal args conflict
   typedef logic [11:0] task_arg_t;

   // One task fits in one host data word
   typedef struct packed {
      ts_t        ts;
      task_type_t ttype;
      task_arg_t  arg;
   } task_t;

   // Dispatch sizing
   localparam int DEFAULT_N_CORES   = 4;
   localparam int DEFAULT_LOG_DEPTH = 3;

endpackage
